//--- include/dkong_macros.svh
`ifndef DKONG_MACROS_SVH
`define DKONG_MACROS_SVH

// Download byte address and store word address
`define DL_AW 16
`define MEM_AW 15

// Data widths
`define BYTE_W 8
`define WORD_W 16

// Loader queue depth, also the credits the download source starts with
`define DL_CREDITS 4

// Word offsets of the ROM regions inside the store
`define MAIN_BASE 'h0000
`define SUB_BASE 'h7000
`define WAV_BASE 'h4000

// Number of byte read ports on the store (main, snd, wav)
`define RD_PORTS 3

`endif

//--- logic/rom_map_pkg.sv
`default_nettype none

`include "dkong_macros.svh"

package rom_map_pkg;

	// Byte address as seen by the download port and the read ports
	typedef logic [`DL_AW-1:0] byte_addr_t;

	// Word address inside the store, 32K words
	typedef logic [`MEM_AW-1:0] word_addr_t;

	typedef logic [`BYTE_W-1:0] rom_byte_t;
	typedef logic [`WORD_W-1:0] rom_word_t;

	// Byte lane write enables
	// bit 1 upper byte, bit 0 lower byte
	typedef logic [1:0] lane_sel_t;

endpackage

`default_nettype wire

//--- logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

	// Board joystick, active high
	// bit 0 right, 1 left, 2 down, 3 up, 4 fire, 5 start, 6 coin, 7 spare
	typedef logic [7:0] joy_t;

	// Game input lines, active low
	// bit 0 U1, 1 D1, 2 L1, 3 R1, 4 J1,
	// bit 5 U2, 6 D2, 7 L2, 8 R2, 9 J2,
	// bit 10 S1, 11 S2, 12 C1, 13 spare
	typedef logic [13:0] game_in_t;

	// Download phases seen by the loader
	typedef enum logic [1:0] {
		idle,
		loading,
		done
	} loader_state_t;

endpackage

`default_nettype wire

//--- logic/rom_loader.sv
`default_nettype none

`include "dkong_macros.svh"

module rom_loader (
	input  wire                          clock_24,
	input  wire                          rst,
	input  wire                          dl_active,
	input  wire                          dl_wr,
	input  wire rom_map_pkg::byte_addr_t dl_addr,
	input  wire rom_map_pkg::rom_byte_t  dl_data,
	input  wire                          wr_ready,
	output logic                         dl_credit,
	output logic                         wr_valid,
	output rom_map_pkg::word_addr_t      wr_addr,
	output rom_map_pkg::lane_sel_t       wr_lanes,
	output rom_map_pkg::rom_byte_t       wr_byte,
	output logic                         loaded_pulse
);
	import rom_map_pkg::*;
	import ctrl_pkg::*;

	localparam int QW = $clog2(`DL_CREDITS);
	localparam int CW = $clog2(`DL_CREDITS + 1);

	byte_addr_t    q_addr [`DL_CREDITS];
	rom_byte_t     q_data [`DL_CREDITS];
	logic [QW-1:0] head;
	logic [QW-1:0] tail;
	logic [CW-1:0] count;
	logic          wr_last;
	logic          push;
	logic          pop;
	logic          drained;
	loader_state_t state;

	function automatic logic [QW-1:0] ptr_inc(input logic [QW-1:0] p);
		return (p == QW'(`DL_CREDITS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push = dl_active & dl_wr & ~wr_last; // Rising edge of the strobe
	assign pop = (count != '0) & (~wr_valid | wr_ready);
	assign drained = (count == '0) & ~wr_valid;

	// One credit per byte handed to the store
	assign dl_credit = wr_valid & wr_ready;
	assign loaded_pulse = (state == loading) & ~dl_active & drained;

	always_ff @(posedge clock_24) begin
		if (push) begin
			q_addr[tail] <= dl_addr;
			q_data[tail] <= dl_data;
		end
	end

	always_ff @(posedge clock_24) begin
		if (rst) begin
			wr_last <= 1'b0;
			head <= '0;
			tail <= '0;
			count <= '0;
			wr_valid <= 1'b0;
		end else begin
			wr_last <= dl_wr;
			if (push)
				tail <= ptr_inc(tail);
			if (pop)
				head <= ptr_inc(head);
			count <= count + CW'(push) - CW'(pop);
			if (pop)
				wr_valid <= 1'b1;
			else if (wr_ready)
				wr_valid <= 1'b0;
		end
	end

	// Head of queue moves into the write register and odd bytes take the upper lane
	always_ff @(posedge clock_24) begin
		if (pop) begin
			wr_addr <= q_addr[head][`MEM_AW:1];
			wr_lanes <= {q_addr[head][0], ~q_addr[head][0]};
			wr_byte <= q_data[head];
		end
	end

	always_ff @(posedge clock_24) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle, done: if (dl_active) state <= loading;
				loading: if (loaded_pulse) state <= done;
				default: state <= idle;
			endcase
		end
	end

	// Source must hold a credit for every strobe
	a_no_overflow: assert property (@(posedge clock_24) disable iff (rst)
		push |-> count < CW'(`DL_CREDITS))
		else $error("download strobe with no credit left");

	// Payload holds while the store stalls
	a_valid_hold: assert property (@(posedge clock_24) disable iff (rst)
		wr_valid && !wr_ready |=> wr_valid && $stable({wr_addr, wr_lanes, wr_byte}));

endmodule

`default_nettype wire

//--- logic/rom_store.sv
`default_nettype none

`include "dkong_macros.svh"

module rom_store (
	input  wire                          clock_24,
	input  wire                          rst,
	input  wire                          wr_valid,
	input  wire rom_map_pkg::word_addr_t wr_addr,
	input  wire rom_map_pkg::lane_sel_t  wr_lanes,
	input  wire rom_map_pkg::rom_byte_t  wr_byte,
	output logic                         wr_ready,
	input  wire                          main_req,
	input  wire rom_map_pkg::byte_addr_t main_addr,
	output rom_map_pkg::rom_byte_t       main_q,
	output logic                         main_q_valid,
	input  wire                          snd_req,
	input  wire rom_map_pkg::byte_addr_t snd_addr,
	output rom_map_pkg::rom_byte_t       snd_q,
	output logic                         snd_q_valid,
	input  wire                          wav_req,
	input  wire rom_map_pkg::byte_addr_t wav_addr,
	output rom_map_pkg::rom_byte_t       wav_q,
	output logic                         wav_q_valid
);
	import rom_map_pkg::*;

	localparam int NP = `RD_PORTS;
	localparam int PW = $clog2(NP);

	// Region offsets, index 0 main, 1 snd, 2 wav
	localparam word_addr_t port_base [NP] = '{
		word_addr_t'(`MAIN_BASE),
		word_addr_t'(`SUB_BASE),
		word_addr_t'(`WAV_BASE)
	};

	rom_word_t     mem [2**`MEM_AW];
	rom_word_t     rd_word;
	rom_byte_t     rd_byte;
	logic          rd_lane;
	byte_addr_t    port_addr [NP];
	word_addr_t    rd_addr;
	logic          sel_lane;
	logic [NP-1:0] req;
	logic [NP-1:0] elig;
	logic [NP-1:0] gnt;
	logic [NP-1:0] vld;
	logic [PW-1:0] rr_ptr;
	logic [PW-1:0] nxt_ptr;
	logic          wr_fire;

	// First eligible port at or after the pointer
	function automatic logic [NP-1:0] rr_pick(input logic [NP-1:0] e, input logic [PW-1:0] p);
		logic [NP-1:0] g;
		int            idx;
		g = '0;
		for (int k = NP - 1; k >= 0; k--) begin
			idx = (int'(p) + k) % NP;
			if (e[idx]) begin
				g = '0;
				g[idx] = 1'b1;
			end
		end
		return g;
	endfunction

	assign port_addr[0] = main_addr;
	assign port_addr[1] = snd_addr;
	assign port_addr[2] = wav_addr;
	assign req = {wav_req, snd_req, main_req};

	assign wr_fire = wr_valid & wr_ready;
	assign elig = req & ~vld; // A port is done while its q_valid is up
	assign gnt = wr_fire ? '0 : rr_pick(elig, rr_ptr);

	always_comb begin
		rd_addr = '0;
		sel_lane = 1'b0;
		nxt_ptr = rr_ptr;
		for (int i = 0; i < NP; i++) begin
			if (gnt[i]) begin
				rd_addr = port_addr[i][`MEM_AW:1] + port_base[i];
				sel_lane = port_addr[i][0];
				nxt_ptr = (i == NP - 1) ? '0 : PW'(i + 1);
			end
		end
	end

	always_ff @(posedge clock_24) begin
		if (wr_fire && wr_lanes[0])
			mem[wr_addr][7:0] <= wr_byte;
		if (wr_fire && wr_lanes[1])
			mem[wr_addr][15:8] <= wr_byte;
		if (|gnt) begin
			rd_word <= mem[rd_addr];
			rd_lane <= sel_lane;
		end
	end

	always_ff @(posedge clock_24) begin
		if (rst) begin
			wr_ready <= 1'b0;
			rr_ptr <= '0;
			vld <= '0;
		end else begin
			wr_ready <= 1'b1;
			vld <= gnt;
			if (|gnt)
				rr_ptr <= nxt_ptr;
		end
	end

	assign rd_byte = rd_lane ? rd_word[15:8] : rd_word[7:0];

	// Only the port flagged by its q_valid takes the byte
	assign main_q = rd_byte;
	assign snd_q = rd_byte;
	assign wav_q = rd_byte;
	assign main_q_valid = vld[0];
	assign snd_q_valid = vld[1];
	assign wav_q_valid = vld[2];

	a_one_valid: assert property (@(posedge clock_24) disable iff (rst)
		$onehot0({wav_q_valid, snd_q_valid, main_q_valid}));

endmodule

`default_nettype wire

//--- logic/game_reset.sv
`default_nettype none

module game_reset (
	input  wire  clock_24,
	input  wire  rst,
	input  wire  loaded_pulse,
	input  wire  menu_reset,
	input  wire  button,
	output logic game_rst
);

	logic rom_loaded;

	// Only a board reset forgets the download
	always_ff @(posedge clock_24) begin
		if (rst)
			rom_loaded <= 1'b0;
		else if (loaded_pulse)
			rom_loaded <= 1'b1;
	end

	always_ff @(posedge clock_24) begin
		if (rst)
			game_rst <= 1'b1;
		else
			game_rst <= menu_reset | button | ~rom_loaded;
	end

endmodule

`default_nettype wire

//--- logic/control_mapper.sv
`default_nettype none

module control_mapper (
	input  wire                   clock_24,
	input  wire                   rst,
	input  wire ctrl_pkg::joy_t   joy_0,
	input  wire ctrl_pkg::joy_t   joy_1,
	input  wire                   rotate,
	output ctrl_pkg::game_in_t    game_in
);
	import ctrl_pkg::*;

	logic [4:0] p1;
	logic [4:0] p2;
	logic       s1;
	logic       s2;
	logic       c1;

	// Returns {fire, right, left, down, up}, active high
	function automatic logic [4:0] map_stick(input joy_t j, input logic rot);
		if (rot)
			return {j[4], j[3], j[2], j[0], j[1]}; // Quarter turn of the stick
		return {j[4], j[0], j[1], j[2], j[3]};
	endfunction

	assign p1 = map_stick(joy_0, rotate);
	assign p2 = map_stick(joy_1, rotate);
	assign s1 = joy_0[5];
	assign c1 = joy_0[6];
	assign s2 = joy_1[5]; // Player two start

	always_ff @(posedge clock_24) begin
		if (rst)
			game_in <= '1;
		else
			game_in <= ~{1'b0, c1, s2, s1, p2, p1}; // Spare line stays inactive
	end

endmodule

`default_nettype wire

//--- logic/dkong_rom_subsys.sv
`default_nettype none

module dkong_rom_subsys (
	input  wire                          clock_24,
	input  wire                          rst,
	input  wire                          dl_active,
	input  wire                          dl_wr,
	input  wire rom_map_pkg::byte_addr_t dl_addr,
	input  wire rom_map_pkg::rom_byte_t  dl_data,
	output wire                          dl_credit,
	input  wire                          menu_reset,
	input  wire                          button,
	input  wire                          main_req,
	input  wire rom_map_pkg::byte_addr_t main_addr,
	output wire rom_map_pkg::rom_byte_t  main_q,
	output wire                          main_q_valid,
	input  wire                          snd_req,
	input  wire rom_map_pkg::byte_addr_t snd_addr,
	output wire rom_map_pkg::rom_byte_t  snd_q,
	output wire                          snd_q_valid,
	input  wire                          wav_req,
	input  wire rom_map_pkg::byte_addr_t wav_addr,
	output wire rom_map_pkg::rom_byte_t  wav_q,
	output wire                          wav_q_valid,
	input  wire ctrl_pkg::joy_t          joy_0,
	input  wire ctrl_pkg::joy_t          joy_1,
	input  wire                          rotate,
	output wire ctrl_pkg::game_in_t      game_in,
	output wire                          game_rst
);
	import rom_map_pkg::*;

	wire             wr_valid;
	wire             wr_ready;
	wire word_addr_t wr_addr;
	wire lane_sel_t  wr_lanes;
	wire rom_byte_t  wr_byte;
	wire             loaded_pulse;

	rom_loader rom_loader (
		.clock_24     ( clock_24     ),
		.rst          ( rst          ),
		.dl_active    ( dl_active    ),
		.dl_wr        ( dl_wr        ),
		.dl_addr      ( dl_addr      ),
		.dl_data      ( dl_data      ),
		.wr_ready     ( wr_ready     ),
		.dl_credit    ( dl_credit    ),
		.wr_valid     ( wr_valid     ),
		.wr_addr      ( wr_addr      ),
		.wr_lanes     ( wr_lanes     ),
		.wr_byte      ( wr_byte      ),
		.loaded_pulse ( loaded_pulse )
	);

	rom_store rom_store (
		.clock_24     ( clock_24     ),
		.rst          ( rst          ),
		.wr_valid     ( wr_valid     ),
		.wr_addr      ( wr_addr      ),
		.wr_lanes     ( wr_lanes     ),
		.wr_byte      ( wr_byte      ),
		.wr_ready     ( wr_ready     ),
		.main_req     ( main_req     ),
		.main_addr    ( main_addr    ),
		.main_q       ( main_q       ),
		.main_q_valid ( main_q_valid ),
		.snd_req      ( snd_req      ),
		.snd_addr     ( snd_addr     ),
		.snd_q        ( snd_q        ),
		.snd_q_valid  ( snd_q_valid  ),
		.wav_req      ( wav_req      ),
		.wav_addr     ( wav_addr     ),
		.wav_q        ( wav_q        ),
		.wav_q_valid  ( wav_q_valid  )
	);

	game_reset game_reset (
		.clock_24     ( clock_24     ),
		.rst          ( rst          ),
		.loaded_pulse ( loaded_pulse ),
		.menu_reset   ( menu_reset   ),
		.button       ( button       ),
		.game_rst     ( game_rst     )
	);

	control_mapper control_mapper (
		.clock_24     ( clock_24     ),
		.rst          ( rst          ),
		.joy_0        ( joy_0        ),
		.joy_1        ( joy_1        ),
		.rotate       ( rotate       ),
		.game_in      ( game_in      )
	);

endmodule

`default_nettype wire

//--- sim/tb_dkong_rom_subsys.sv
`default_nettype none

`include "dkong_macros.svh"

module tb_dkong_rom_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	import rom_map_pkg::*;
	import ctrl_pkg::*;

	localparam int N_BYTES = 600;
	localparam int N_READS = 90;
	localparam int N_SIM = 40;
	localparam int N_JOY = 64;
	localparam int READ_LIMIT = 4;
	localparam int DRAIN_LIMIT = 4 * `DL_CREDITS;
	// Per byte 16, per read 8, per joystick sample 4, plus setup
	localparam int TIMEOUT_CYCLES = 300 + N_BYTES * 16 + (N_READS + N_SIM) * 8 + N_JOY * 4;

	logic       clock_24;
	logic       rst;
	logic       dl_active;
	logic       dl_wr;
	byte_addr_t dl_addr;
	rom_byte_t  dl_data;
	logic       dl_credit;
	logic       menu_reset;
	logic       button;
	joy_t       joy_0;
	joy_t       joy_1;
	logic       rotate;
	game_in_t   game_in;
	logic       game_rst;

	// Read port index 0 is main, 1 snd and 2 wav
	logic       req [3];
	byte_addr_t addr [3];
	rom_byte_t  q [3];
	logic       q_valid [3];

	string      port_name [3] = '{"main", "snd", "wav"};
	localparam word_addr_t region_base [3] = '{
		word_addr_t'(0), word_addr_t'(`SUB_BASE), word_addr_t'(`WAV_BASE)};

	rom_byte_t  model_mem [2**`DL_AW];
	byte_addr_t written [$];
	int         credits = `DL_CREDITS;
	int         sent = 0;
	int         returned = 0;
	int         cycle_count = 0;
	logic       expect_rst_high = 1'b0;

	dkong_rom_subsys uut (
		.*,
		.main_req     ( req[0]     ),
		.main_addr    ( addr[0]    ),
		.main_q       ( q[0]       ),
		.main_q_valid ( q_valid[0] ),
		.snd_req      ( req[1]     ),
		.snd_addr     ( addr[1]    ),
		.snd_q        ( q[1]       ),
		.snd_q_valid  ( q_valid[1] ),
		.wav_req      ( req[2]     ),
		.wav_addr     ( addr[2]    ),
		.wav_q        ( q[2]       ),
		.wav_q_valid  ( q_valid[2] )
	);

	initial begin
		clock_24 = 1'b0;
		forever #4 clock_24 = ~clock_24;
	end

	task automatic fail_run(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "simulation stopped");
		end
	endtask

	task automatic next_cycle();
		@(posedge clock_24);
		#1;
	endtask

	// Word is offset by the region and an odd address picks the upper byte
	function automatic rom_byte_t expected_byte(input int p, input byte_addr_t a);
		word_addr_t w;
		w = a[`DL_AW-1:1] + region_base[p];
		return model_mem[{w, a[0]}];
	endfunction

	function automatic byte_addr_t port_addr_for(input int p, input byte_addr_t loc);
		return loc - {region_base[p], 1'b0};
	endfunction

	function automatic logic [3:0] dirs(input joy_t j, input logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		up = rot ? j[1] : j[3]; // Quarter turn puts left onto up
		down = rot ? j[0] : j[2];
		left = rot ? j[2] : j[1];
		right = rot ? j[3] : j[0];
		return {right, left, down, up};
	endfunction

	function automatic game_in_t expected_in(input joy_t j0, input joy_t j1, input logic rot);
		game_in_t g;
		g = '0;
		g[3:0] = dirs(j0, rot);
		g[4] = j0[4];
		g[8:5] = dirs(j1, rot);
		g[9] = j1[4];
		g[10] = j0[5];
		g[11] = j1[5];
		g[12] = j0[6];
		return ~g; // Lines are active low so the spare stays high
	endfunction

	task automatic send_byte(input byte_addr_t a, input rom_byte_t d);
		while (credits == 0)
			next_cycle();
		dl_wr = 1'b1;
		dl_addr = a;
		dl_data = d;
		credits--;
		sent++;
		next_cycle();
		dl_wr = 1'b0;
		repeat ($urandom_range(0, 3)) next_cycle();
		next_cycle();
	endtask

	task automatic read_port(input int p, input byte_addr_t a);
		int        waited;
		rom_byte_t exp;
		exp = expected_byte(p, a);
		req[p] = 1'b1;
		addr[p] = a;
		waited = 0;
		do begin
			@(negedge clock_24);
			waited++;
		end while (!q_valid[p] && waited < READ_LIMIT);
		if (!q_valid[p])
			fail_run($sformatf("no q_valid on port %s within %0d cycles", port_name[p], READ_LIMIT));
		check_value({port_name[p], "_q"}, 32'(q[p]), 32'(exp));
		next_cycle();
		req[p] = 1'b0;
	endtask

	task automatic pulse_reset_source(input logic use_button);
		next_cycle();
		if (use_button)
			button = 1'b1;
		else
			menu_reset = 1'b1;
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 0);
		next_cycle();
		button = 1'b0;
		menu_reset = 1'b0;
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 1); // One cycle lag
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 0);
	endtask

	always @(negedge clock_24) begin
		if (dl_credit) begin
			credits++;
			returned++;
			if (credits > `DL_CREDITS)
				fail_run("credit returned with no byte outstanding");
		end
		if (expect_rst_high)
			check_value("game_rst", 32'(game_rst), 1);
	end

	always @(posedge clock_24) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES)
			fail_run("run did not finish within the cycle limit");
	end

	initial begin
		byte_addr_t a;
		rom_byte_t  d;
		byte_addr_t sim_addr [3];
		int         p;
		int         waited;
		game_in_t   prev_in;
		game_in_t   cur_in;
		void'($urandom(82));
		rst = 1'b1;
		{dl_active, dl_wr, menu_reset, button, rotate} = '0;
		dl_addr = '0;
		dl_data = '0;
		joy_0 = '0;
		joy_1 = '0;
		for (int k = 0; k < 3; k++) begin
			req[k] = 1'b0;
			addr[k] = '0;
		end
		next_cycle();
		expect_rst_high = 1'b1;
		repeat (4) next_cycle();
		rst = 1'b0;
		@(negedge clock_24);
		check_value("dl_credit", 32'(dl_credit), 0);
		for (int k = 0; k < 3; k++)
			check_value({port_name[k], "_q_valid"}, 32'(q_valid[k]), 0);

		next_cycle();
		dl_active = 1'b1;
		next_cycle();
		for (int i = 0; i < N_BYTES; i++) begin
			a = byte_addr_t'($urandom);
			d = rom_byte_t'($urandom);
			model_mem[a] = d;
			written.push_back(a);
			send_byte(a, d);
		end
		waited = 0;
		while (credits != `DL_CREDITS && waited < DRAIN_LIMIT) begin
			next_cycle();
			waited++;
		end
		check_value("credits_returned", 32'(returned), 32'(sent));

		// With the queue empty the release comes two cycles after dl_active falls
		expect_rst_high = 1'b0;
		dl_active = 1'b0;
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 1);
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 1);
		@(negedge clock_24);
		check_value("game_rst", 32'(game_rst), 0);
		pulse_reset_source(1'b0);
		pulse_reset_source(1'b1);

		next_cycle();
		for (int i = 0; i < N_READS; i++) begin
			p = int'($urandom_range(0, 2));
			a = written[$urandom_range(0, written.size() - 1)];
			read_port(p, port_addr_for(p, a));
			repeat ($urandom_range(0, 2)) next_cycle();
		end
		for (int i = 0; i < N_SIM; i++) begin
			for (int k = 0; k < 3; k++)
				sim_addr[k] = port_addr_for(k, written[$urandom_range(0, written.size() - 1)]);
			fork
				read_port(0, sim_addr[0]);
				read_port(1, sim_addr[1]);
				read_port(2, sim_addr[2]);
			join
			next_cycle();
		end

		prev_in = expected_in(joy_0, joy_1, rotate);
		for (int i = 0; i < N_JOY; i++) begin
			next_cycle();
			joy_0 = joy_t'($urandom);
			joy_1 = joy_t'($urandom);
			rotate = 1'($urandom_range(0, 1));
			cur_in = expected_in(joy_0, joy_1, rotate);
			@(negedge clock_24);
			check_value("game_in", 32'(game_in), 32'(prev_in));
			@(negedge clock_24);
			check_value("game_in", 32'(game_in), 32'(cur_in));
			prev_in = cur_in;
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
logic/rom_map_pkg.sv
logic/ctrl_pkg.sv
logic/rom_loader.sv
logic/rom_store.sv
logic/game_reset.sv
logic/control_mapper.sv
logic/dkong_rom_subsys.sv
sim/tb_dkong_rom_subsys.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f flist.f --top-module tb_dkong_rom_subsys \
	-o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1
grep -qs "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }
